//--- design/core_defs.svh
// core width and reset parameters
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path and address width
`define CPU_WIDTH 32

// register index width, 32 architectural registers
`define REG_ADDR_WIDTH 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- design/rv_isa_pkg.sv
// rv32i instruction encodings
package rv_isa_pkg;

    // major opcodes in inst[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011, // register-immediate alu
        op_reg    = 7'b0110011  // register-register alu
    } opcode_e;

    // funct3 for op_imm and op_reg, 3'b011 (sltu) is not supported
    typedef enum logic [2:0] {
        f3_add_sub = 3'b000, // bit 30 picks sub on op_reg
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101, // bit 30 picks sra
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_alu_e;

    // funct3 for op_branch, unsigned compares left out
    typedef enum logic [2:0] {
        f3_beq = 3'b000,
        f3_bne = 3'b001,
        f3_blt = 3'b100,
        f3_bge = 3'b101
    } funct3_br_e;

endpackage

//--- design/core_ctrl_pkg.sv
// internal control encodings
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,    // signed
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i,
        imm_i_shamt, // zero-extended inst[24:20]
        imm_u,
        imm_j,
        imm_b
    } imm_sel_e;

    typedef enum logic {src_a_reg, src_a_pc} src_a_e;

    typedef enum logic [1:0] {src_b_reg, src_b_imm, src_b_four} src_b_e;

    // control-transfer kind
    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_jal, br_jalr
    } br_cond_e;

endpackage

//--- design/fetch_stage.sv
// program counter and next-pc select
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  take_branch,
    input  logic [`CPU_WIDTH-1:0] target,
    output logic [`CPU_WIDTH-1:0] pc,
    output logic                  inst_valid
);

    logic                  started; // set one cycle after reset release
    logic [`CPU_WIDTH-1:0] next_pc;

    assign next_pc = take_branch ? target : pc + `CPU_WIDTH'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `RESET_PC;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (started) begin
                pc <= next_pc; // hold RESET_PC through the idle cycle
            end
        end
    end

    assign inst_valid = started;

endmodule

//--- design/decode_stage.sv
// control decoder and immediate generator
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_stage import rv_isa_pkg::*; import core_ctrl_pkg::*; (
    input  logic [`CPU_WIDTH-1:0]      inst,
    input  logic                       inst_valid,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic                       reg_wen,
    output logic [`REG_ADDR_WIDTH-1:0] reg_waddr,
    output logic [`CPU_WIDTH-1:0]      imm,
    output alu_op_e                    alu_op,
    output src_a_e                     src_a_sel,
    output src_b_e                     src_b_sel,
    output br_cond_e                   br_cond,
    output logic                       illegal_inst
);

    logic [2:0] funct3;
    logic       alt;      // funct7 bit 5
    logic       wen_raw;  // opcode writes rd
    logic       bad;      // unsupported encoding
    imm_sel_e   imm_sel;

    // alu funct3 decode shared by op_imm and op_reg
    function automatic void decode_alu(input logic [2:0] f3, input logic use_alt,
                                       output alu_op_e op, output logic unknown);
        op      = alu_add;
        unknown = 1'b0;
        case (funct3_alu_e'(f3))
            f3_add_sub: op = use_alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = use_alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            f3_and:     op = alu_and;
            default:    unknown = 1'b1; // sltu
        endcase
    endfunction

    assign funct3    = inst[14:12];
    assign alt       = inst[30];
    assign rs1_addr  = inst[19:15];
    assign rs2_addr  = inst[24:20];
    assign reg_waddr = inst[11:7];

    always_comb begin
        alu_op    = alu_add;
        src_a_sel = src_a_reg;
        src_b_sel = src_b_reg;
        br_cond   = br_none;
        imm_sel   = imm_i;
        wen_raw   = 1'b0;
        bad       = 1'b0;
        case (opcode_e'(inst[6:0]))
            op_lui: begin
                imm_sel   = imm_u;
                src_b_sel = src_b_imm;
                alu_op    = alu_pass_b;
                wen_raw   = 1'b1;
            end
            op_auipc: begin
                imm_sel   = imm_u;
                src_a_sel = src_a_pc;
                src_b_sel = src_b_imm;
                wen_raw   = 1'b1;
            end
            op_jal, op_jalr: begin
                src_a_sel = src_a_pc; // link value pc + 4
                src_b_sel = src_b_four;
                wen_raw   = 1'b1;
                if (inst[3]) begin
                    imm_sel = imm_j;
                    br_cond = br_jal;
                end else begin
                    br_cond = br_jalr;
                    bad     = (funct3 != 3'b000);
                end
            end
            op_branch: begin
                imm_sel = imm_b;
                alu_op  = alu_sub; // compare rs1 against rs2
                case (funct3_br_e'(funct3))
                    f3_beq:  br_cond = br_eq;
                    f3_bne:  br_cond = br_ne;
                    f3_blt:  br_cond = br_lt;
                    f3_bge:  br_cond = br_ge;
                    default: bad = 1'b1;
                endcase
            end
            op_imm: begin
                src_b_sel = src_b_imm;
                wen_raw   = 1'b1;
                if (funct3 == f3_sll || funct3 == f3_srl_sra) begin
                    imm_sel = imm_i_shamt;
                end
                // bit 30 is immediate data except on srai
                decode_alu(funct3, alt && (funct3 == f3_srl_sra), alu_op, bad);
            end
            op_reg: begin
                wen_raw = 1'b1;
                decode_alu(funct3, alt, alu_op, bad);
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            br_cond = br_none; // safe control set
            wen_raw = 1'b0;
        end
    end

    always_comb begin
        case (imm_sel)
            imm_i_shamt: imm = {{(`CPU_WIDTH-5){1'b0}}, inst[24:20]};
            imm_u:       imm = {inst[31:12], 12'b0};
            imm_j:       imm = {{(`CPU_WIDTH-20){inst[31]}}, inst[19:12], inst[20],
                                inst[30:21], 1'b0};
            imm_b:       imm = {{(`CPU_WIDTH-12){inst[31]}}, inst[7], inst[30:25],
                                inst[11:8], 1'b0};
            default:     imm = {{(`CPU_WIDTH-12){inst[31]}}, inst[31:20]};
        endcase
    end

    assign reg_wen      = inst_valid && wen_raw && (reg_waddr != '0); // x0 never written
    assign illegal_inst = inst_valid && bad;

endmodule

//--- design/reg_file.sv
// integer register file
`timescale 1ns/1ps
`include "core_defs.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       reg_wen,
    input  logic [`REG_ADDR_WIDTH-1:0] reg_waddr,
    input  logic [`CPU_WIDTH-1:0]      reg_wdata,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [`CPU_WIDTH-1:0]      rs1_data,
    output logic [`CPU_WIDTH-1:0]      rs2_data
);

    localparam int REG_COUNT = 1 << `REG_ADDR_WIDTH;

    logic [`CPU_WIDTH-1:0] regs [1:REG_COUNT-1]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wen) begin
            regs[reg_waddr] <= reg_wdata; // decoder never targets x0
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- design/execute_stage.sv
// operand select, alu and branch resolve
`timescale 1ns/1ps
`include "core_defs.svh"

module execute_stage import core_ctrl_pkg::*; (
    input  logic [`CPU_WIDTH-1:0] pc,
    input  logic [`CPU_WIDTH-1:0] rs1_data,
    input  logic [`CPU_WIDTH-1:0] rs2_data,
    input  logic [`CPU_WIDTH-1:0] imm,
    input  alu_op_e               alu_op,
    input  src_a_e                src_a_sel,
    input  src_b_e                src_b_sel,
    input  br_cond_e              br_cond,
    output logic [`CPU_WIDTH-1:0] alu_res,
    output logic                  take_branch,
    output logic [`CPU_WIDTH-1:0] target
);

    logic [`CPU_WIDTH-1:0] op_a;
    logic [`CPU_WIDTH-1:0] op_b;
    logic [`CPU_WIDTH-1:0] diff;
    logic [4:0]            shamt;
    logic                  zero;
    logic                  less; // signed op_a < op_b

    assign op_a = (src_a_sel == src_a_pc) ? pc : rs1_data;

    always_comb begin
        case (src_b_sel)
            src_b_imm:  op_b = imm;
            src_b_four: op_b = `CPU_WIDTH'd4;
            default:    op_b = rs2_data;
        endcase
    end

    // one subtractor serves sub, slt and the branch compares
    assign diff  = op_a - op_b;
    assign zero  = (diff == '0);
    assign less  = (op_a[`CPU_WIDTH-1] != op_b[`CPU_WIDTH-1]) ? op_a[`CPU_WIDTH-1]
                                                              : diff[`CPU_WIDTH-1];
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            alu_sub:    alu_res = diff;
            alu_sll:    alu_res = op_a << shamt;
            alu_slt:    alu_res = {{(`CPU_WIDTH-1){1'b0}}, less};
            alu_xor:    alu_res = op_a ^ op_b;
            alu_srl:    alu_res = op_a >> shamt;
            alu_sra:    alu_res = $signed(op_a) >>> shamt;
            alu_or:     alu_res = op_a | op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_pass_b: alu_res = op_b;
            default:    alu_res = op_a + op_b; // alu_add
        endcase
    end

    always_comb begin
        case (br_cond)
            br_eq:            take_branch = zero;
            br_ne:            take_branch = !zero;
            br_lt:            take_branch = less;
            br_ge:            take_branch = !less;
            br_jal, br_jalr:  take_branch = 1'b1;
            default:          take_branch = 1'b0;
        endcase
    end

    // jalr clears bit 0 of rs1 + imm
    assign target = (br_cond == br_jalr) ? ((rs1_data + imm) & ~`CPU_WIDTH'd1) : pc + imm;

endmodule

//--- design/rv_core_top.sv
// single-cycle rv32i core
`timescale 1ns/1ps
`include "core_defs.svh"

module rv_core_top import core_ctrl_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CPU_WIDTH-1:0]      inst,
    output logic [`CPU_WIDTH-1:0]      pc,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_addr,
    output logic [`CPU_WIDTH-1:0]      wb_data,
    output logic                       illegal_inst
);

    logic                       inst_valid;
    logic                       take_branch;
    logic [`CPU_WIDTH-1:0]      target;
    logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [`CPU_WIDTH-1:0]      rs1_data;
    logic [`CPU_WIDTH-1:0]      rs2_data;
    logic                       reg_wen;
    logic [`REG_ADDR_WIDTH-1:0] reg_waddr;
    logic [`CPU_WIDTH-1:0]      imm;
    logic [`CPU_WIDTH-1:0]      alu_res;
    alu_op_e                    alu_op;
    src_a_e                     src_a_sel;
    src_b_e                     src_b_sel;
    br_cond_e                   br_cond;

    fetch_stage i_fetch (
        .clk         (clk),
        .reset       (reset),
        .take_branch (take_branch),
        .target      (target),
        .pc          (pc),
        .inst_valid  (inst_valid)
    );

    decode_stage i_decode (
        .inst         (inst),
        .inst_valid   (inst_valid),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .reg_wen      (reg_wen),
        .reg_waddr    (reg_waddr),
        .imm          (imm),
        .alu_op       (alu_op),
        .src_a_sel    (src_a_sel),
        .src_b_sel    (src_b_sel),
        .br_cond      (br_cond),
        .illegal_inst (illegal_inst)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .reset     (reset),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (alu_res), // every write-back comes from the alu
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    execute_stage i_execute (
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .alu_op      (alu_op),
        .src_a_sel   (src_a_sel),
        .src_b_sel   (src_b_sel),
        .br_cond     (br_cond),
        .alu_res     (alu_res),
        .take_branch (take_branch),
        .target      (target)
    );

    // write-back strobe seen by the environment
    assign wb_valid = reg_wen;
    assign wb_addr  = reg_waddr;
    assign wb_data  = alu_res;

endmodule

//--- bench/tb_rv_core.sv
// rv32i core trace testbench
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_rv_core import rv_isa_pkg::*; import core_ctrl_pkg::*; ;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_STEPS    = 40;
    localparam int SAMPLE_LEAD  = 5; // ns ahead of the retiring edge

    logic                       clk;
    logic                       reset;
    logic [`CPU_WIDTH-1:0]      inst;
    logic [`CPU_WIDTH-1:0]      pc;
    logic                       wb_valid;
    logic [`REG_ADDR_WIDTH-1:0] wb_addr;
    logic [`CPU_WIDTH-1:0]      wb_data;
    logic                       illegal_inst;

    // trace table, one row per retired instruction
    logic [`CPU_WIDTH-1:0]      tbl_pc    [MAX_STEPS];
    logic [`CPU_WIDTH-1:0]      tbl_inst  [MAX_STEPS];
    logic                       tbl_wbv   [MAX_STEPS];
    logic [`REG_ADDR_WIDTH-1:0] tbl_wba   [MAX_STEPS];
    logic [`CPU_WIDTH-1:0]      tbl_wbd   [MAX_STEPS];
    logic                       tbl_ill   [MAX_STEPS];
    int                         num_steps;
    int                         mismatch_count;
    int                         other_count;
    int                         cycle_count;

    rv_core_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .pc           (pc),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .illegal_inst (illegal_inst)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    task automatic add_step(logic [31:0] exp_pc, logic [31:0] word, logic wbv,
                            logic [4:0] wba, logic [31:0] wbd, logic ill);
        tbl_pc[num_steps]   = exp_pc;
        tbl_inst[num_steps] = word;
        tbl_wbv[num_steps]  = wbv;
        tbl_wba[num_steps]  = wba;
        tbl_wbd[num_steps]  = wbd;
        tbl_ill[num_steps]  = ill;
        num_steps++;
    endtask

    task automatic load_trace();
        add_step(32'h00, enc_i(12'hFFB, 5'd0, f3_add_sub, 5'd1, op_imm), 1, 5'd1, 32'hFFFF_FFFB, 0);
        add_step(32'h04, enc_i(12'd12, 5'd0, f3_add_sub, 5'd2, op_imm), 1, 5'd2, 32'h0000_000C, 0);
        add_step(32'h08, enc_i(12'd4, 5'd1, f3_slt, 5'd3, op_imm), 1, 5'd3, 32'h0000_0001, 0);
        add_step(32'h0C, enc_i(12'd10, 5'd2, f3_and, 5'd4, op_imm), 1, 5'd4, 32'h0000_0008, 0);
        add_step(32'h10, enc_i(12'd7, 5'd2, f3_or, 5'd5, op_imm), 1, 5'd5, 32'h0000_000F, 0);
        add_step(32'h14, enc_i(12'hFFF, 5'd1, f3_xor, 5'd6, op_imm), 1, 5'd6, 32'h0000_0004, 0);
        add_step(32'h18, enc_i(12'd4, 5'd2, f3_sll, 5'd7, op_imm), 1, 5'd7, 32'h0000_00C0, 0);
        add_step(32'h1C, enc_i(12'd28, 5'd1, f3_srl_sra, 5'd8, op_imm), 1, 5'd8, 32'h0000_000F, 0);
        add_step(32'h20, enc_i(12'h401, 5'd1, f3_srl_sra, 5'd9, op_imm), 1, 5'd9, 32'hFFFF_FFFD, 0);
        add_step(32'h24, {20'h12345, 5'd10, op_lui}, 1, 5'd10, 32'h1234_5000, 0);
        add_step(32'h28, {20'h00001, 5'd11, op_auipc}, 1, 5'd11, 32'h0000_1028, 0);
        add_step(32'h2C, enc_r(7'h00, 5'd2, 5'd1, f3_add_sub, 5'd12), 1, 5'd12, 32'h0000_0007, 0);
        add_step(32'h30, enc_r(7'h20, 5'd2, 5'd0, f3_add_sub, 5'd13), 1, 5'd13, 32'hFFFF_FFF4, 0);
        add_step(32'h34, enc_r(7'h00, 5'd5, 5'd1, f3_and, 5'd14), 1, 5'd14, 32'h0000_000B, 0);
        add_step(32'h38, enc_r(7'h00, 5'd2, 5'd4, f3_or, 5'd15), 1, 5'd15, 32'h0000_000C, 0);
        add_step(32'h3C, enc_r(7'h00, 5'd5, 5'd1, f3_xor, 5'd16), 1, 5'd16, 32'hFFFF_FFF4, 0);
        add_step(32'h40, enc_r(7'h00, 5'd2, 5'd1, f3_slt, 5'd17), 1, 5'd17, 32'h0000_0001, 0);
        add_step(32'h44, enc_r(7'h00, 5'd11, 5'd3, f3_sll, 5'd18), 1, 5'd18, 32'h0000_0100, 0);
        add_step(32'h48, enc_r(7'h00, 5'd6, 5'd1, f3_srl_sra, 5'd19), 1, 5'd19, 32'h0FFF_FFFF, 0);
        add_step(32'h4C, enc_r(7'h20, 5'd6, 5'd1, f3_srl_sra, 5'd20), 1, 5'd20, 32'hFFFF_FFFF, 0);
        add_step(32'h50, enc_r(7'h00, 5'd2, 5'd1, f3_add_sub, 5'd0), 0, 5'd0, 32'h0, 0); // x0
        add_step(32'h54, enc_b(13'd8, 5'd15, 5'd2, f3_beq), 0, 5'd0, 32'h0, 0);  // taken
        add_step(32'h5C, enc_b(13'd8, 5'd2, 5'd1, f3_beq), 0, 5'd0, 32'h0, 0);
        add_step(32'h60, enc_b(13'd12, 5'd2, 5'd1, f3_bne), 0, 5'd0, 32'h0, 0); // taken
        add_step(32'h6C, enc_b(13'd8, 5'd15, 5'd2, f3_bne), 0, 5'd0, 32'h0, 0);
        add_step(32'h70, enc_b(13'd8, 5'd2, 5'd1, f3_blt), 0, 5'd0, 32'h0, 0);  // signed taken
        add_step(32'h78, enc_b(13'd8, 5'd1, 5'd2, f3_blt), 0, 5'd0, 32'h0, 0);
        add_step(32'h7C, enc_b(13'h44, 5'd15, 5'd2, f3_bge), 0, 5'd0, 32'h0, 0); // equal
        add_step(32'hC0, enc_b(13'd8, 5'd2, 5'd1, f3_bge), 0, 5'd0, 32'h0, 0);
        add_step(32'hC4, enc_j(21'h1F_FFBC, 5'd21), 1, 5'd21, 32'h0000_00C8, 0); // back 0x44
        add_step(32'h80, enc_i(12'h039, 5'd21, 3'b000, 5'd22, op_jalr), 1, 5'd22, 32'h84, 0);
        add_step(32'h100, enc_i(12'd0, 5'd2, 3'b010, 5'd1, 7'b0000011), 0, 5'd0, 32'h0, 1);
        add_step(32'h104, enc_r(7'h00, 5'd2, 5'd1, f3_add_sub, 5'd23), 1, 5'd23, 32'h7, 0);
        add_step(32'h108, enc_r(7'h20, 5'd0, 5'd2, f3_add_sub, 5'd24), 1, 5'd24, 32'hC, 0); // x0
    endtask

    task automatic check_pc(logic [`CPU_WIDTH-1:0] expected, string what);
        if (pc !== expected) begin
            $display("mismatch at %0t: %s pc %h, expected %h", $time, what, pc, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_wb(logic valid, logic [`REG_ADDR_WIDTH-1:0] addr,
                            logic [`CPU_WIDTH-1:0] data, string what);
        if (wb_valid !== valid) begin
            $display("mismatch at %0t: %s wb_valid %b, expected %b", $time, what, wb_valid, valid);
            mismatch_count++;
        end else if (valid && (wb_addr !== addr || wb_data !== data)) begin
            $display("mismatch at %0t: %s write x%0d=%h, expected x%0d=%h", $time, what,
                     wb_addr, wb_data, addr, data);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(logic actual, logic expected, string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic close_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    initial begin : stimulus
        reset          = 1'b1;
        inst           = enc_i(12'd99, 5'd0, f3_add_sub, 5'd1, op_imm); // must be ignored
        mismatch_count = 0;
        other_count    = 0;
        num_steps      = 0;
        load_trace();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #(CLK_PERIOD / 2 - SAMPLE_LEAD);
        check_pc(`RESET_PC, "idle cycle");
        check_flag(wb_valid, 1'b0, "idle cycle wb_valid");
        check_flag(illegal_inst, 1'b0, "idle cycle illegal_inst");
        for (int i = 0; i < num_steps; i++) begin
            @(negedge clk);
            inst = tbl_inst[i];
            #(CLK_PERIOD / 2 - SAMPLE_LEAD); // outputs settled before the edge
            check_pc(tbl_pc[i], $sformatf("step %0d", i));
            check_wb(tbl_wbv[i], tbl_wba[i], tbl_wbd[i], $sformatf("step %0d", i));
            check_flag(illegal_inst, tbl_ill[i], $sformatf("step %0d illegal_inst", i));
        end
        close_run();
    end

    initial begin : watchdog
        cycle_count = 0;
        do begin
            @(posedge clk);
            if (!reset) cycle_count++;
        end while (cycle_count < num_steps + 20);
        $display("timeout: trace did not finish within %0d cycles after reset", cycle_count);
        other_count++;
        close_run();
    end

endmodule

//--- list.f
+incdir+design
design/rv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/rv_core_top.sv
bench/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_rv_core -f list.f -o tb_rv_core \
    && ./obj_dir/tb_rv_core > sim.log 2>&1 \
    || { echo "build or run error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
